/* instr_mem.hex */
// one 32-bit instruction word per line in hex, word index 0 to 31
00100093
00208133
00208463
0000a183
00312023
008000ef
12345237
00420293
000080e7
00530313
0062a023
00730393
fe208ee3
00838413
0093a483
00a48533
0100006f
00b58593
00c62623
00d68693
00070067
00e78793
00f82823
01088893
0128e463
01198993
013a2a23
014a8a93
ff9ff0ef
015b0b13
016b8b93
000000e7

/* all.f */
common/fe_pkg.sv
source/fetch_pc_gen.sv
source/fetch_lane.sv
source/issue_pair_pack.sv
source/fe_top.sv
verification/fe_checker.sv
verification/fe_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= fe_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)

/* verification/fe_tb.sv */
// fetch front end testbench with clock, reset, random stimulus and test sequence
// the checker instance compares every accepted pair
`timescale 1ns/10ps

module fe_tb;
  import fe_pkg::*;

  // cycles without progress before a wait gives up
  localparam int timeout_cycles_c = 400;

  logic           clk;
  logic           reset;
  logic           fe_cmd_v;
  fe_cmd_opcode_e fe_cmd_opcode;
  vaddr_t         fe_cmd_vaddr;
  logic           queue_ready;
  logic           queue0_v;
  vaddr_t         queue0_pc;
  instr_t         queue0_instr;
  logic           queue1_v;
  vaddr_t         queue1_pc;
  instr_t         queue1_instr;
  int             pairs;
  int             ctrl_pairs;
  int             check_errors;
  logic [31:0]    rng_state;
  bit             timed_out;
  int             test_count;
  int             failed_tests;

  fe_top i_fe_top (
    .clk_i           (clk),
    .reset_i         (reset),
    .fe_cmd_v_i      (fe_cmd_v),
    .fe_cmd_opcode_i (fe_cmd_opcode),
    .fe_cmd_vaddr_i  (fe_cmd_vaddr),
    .queue_ready_i   (queue_ready),
    .queue0_v_o      (queue0_v),
    .queue0_pc_o     (queue0_pc),
    .queue0_instr_o  (queue0_instr),
    .queue1_v_o      (queue1_v),
    .queue1_pc_o     (queue1_pc),
    .queue1_instr_o  (queue1_instr)
  );

  fe_checker i_fe_checker (
    .clk_i           (clk),
    .reset_i         (reset),
    .fe_cmd_v_i      (fe_cmd_v),
    .fe_cmd_opcode_i (fe_cmd_opcode),
    .fe_cmd_vaddr_i  (fe_cmd_vaddr),
    .queue_ready_i   (queue_ready),
    .queue0_v_i      (queue0_v),
    .queue0_pc_i     (queue0_pc),
    .queue0_instr_i  (queue0_instr),
    .queue1_v_i      (queue1_v),
    .queue1_pc_i     (queue1_pc),
    .queue1_instr_i  (queue1_instr),
    .pairs_o         (pairs),
    .ctrl_pairs_o    (ctrl_pairs),
    .errors_o        (check_errors)
  );

  // 40 ns period
  initial
  begin
    clk = 1'b0;
    forever
    begin
      #20;
      clk = ~clk;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic step_random();
    rng_state = xorshift32(rng_state);
  endtask

  task automatic drive_redirect(input vaddr_t addr);
    fe_cmd_v      <= 1'b1;
    fe_cmd_opcode <= e_op_pc_redirect;
    fe_cmd_vaddr  <= addr;
  endtask

  task automatic note_timeout(input string what);
    $display("timeout: %s made no progress within %0d cycles", what, timeout_cycles_c);
    timed_out = 1'b1;
  endtask

  // run until count more pairs are accepted
  // ready and redirects optionally random
  task automatic collect_pairs(input int count, input bit random_ready, input bit random_cmd);
    int start;
    int seen;
    int idle;
    start = pairs;
    seen = pairs;
    idle = 0;
    while ((pairs - start) < count && !timed_out)
    begin
      @(posedge clk);
      step_random();
      fe_cmd_v    <= 1'b0;
      queue_ready <= random_ready ? (rng_state[0] | rng_state[1]) : 1'b1;
      if (random_cmd && rng_state[6:3] == 4'd0)
      begin
        drive_redirect(rng_state & 32'hffff_fffc);
      end
      if (pairs != seen)
      begin
        seen = pairs;
        idle = 0;
      end
      else
      begin
        idle++;
      end
      if (idle > timeout_cycles_c)
      begin
        note_timeout("pair collection");
      end
    end
  endtask

  // park a control-transfer pair with ready low
  // then accept it at the same edge that samples a redirect
  task automatic redirect_on_ctrl(input int rounds);
    int done;
    int idle;
    done = 0;
    idle = 0;
    while (done < rounds && !timed_out)
    begin
      @(posedge clk);
      fe_cmd_v <= 1'b0;
      idle++;
      if (queue0_v && !queue1_v && !queue_ready)
      begin
        step_random();
        queue_ready <= 1'b1;
        drive_redirect(rng_state & 32'hffff_fffc);
        done++;
        idle = 0;
      end
      else
      begin
        queue_ready <= !queue_ready;
      end
      if (idle > timeout_cycles_c)
      begin
        note_timeout("control transfer search");
      end
    end
  endtask

  // wait, hold off a random number of cycles, then restart with a redirect
  task automatic wait_then_redirect(input int rounds);
    int r;
    int hold;
    int i;
    for (r = 0; r < rounds && !timed_out; r++)
    begin
      @(posedge clk);
      step_random();
      fe_cmd_v      <= 1'b1;
      fe_cmd_opcode <= e_op_wait;
      queue_ready   <= rng_state[0];
      hold = 3 + int'(rng_state[10:8]);
      for (i = 0; i < hold; i++)
      begin
        @(posedge clk);
        step_random();
        fe_cmd_v    <= 1'b0;
        queue_ready <= rng_state[0];
      end
      @(posedge clk);
      step_random();
      drive_redirect(rng_state & 32'hffff_fffc);
      collect_pairs(6, 1'b1, 1'b0);
    end
  endtask

  task automatic run_test(input int which);
    string name;
    int    pairs_start;
    int    errors_start;
    int    ctrl_start;
    bit    ok;
    pairs_start = pairs;
    ctrl_start = ctrl_pairs;
    // reset errors land before the first test starts
    errors_start = (which == 0) ? 0 : check_errors;
    case (which)
      0:
      begin
        name = "reset";
        collect_pairs(1, 1'b0, 1'b0);
      end
      1:
      begin
        name = "straight_line";
        collect_pairs(24, 1'b0, 1'b0);
      end
      2:
      begin
        name = "control_transfer";
        collect_pairs(32, 1'b0, 1'b0);
      end
      3:
      begin
        name = "back_pressure";
        collect_pairs(80, 1'b1, 1'b0);
      end
      4:
      begin
        name = "redirect";
        collect_pairs(80, 1'b1, 1'b1);
        redirect_on_ctrl(4);
        collect_pairs(8, 1'b1, 1'b0);
      end
      default:
      begin
        name = "wait";
        wait_then_redirect(4);
      end
    endcase
    @(posedge clk);
    ok = !timed_out && (check_errors == errors_start);
    // the control-transfer test must actually meet one
    if (which == 2 && ctrl_pairs == ctrl_start)
    begin
      ok = 1'b0;
    end
    test_count++;
    if (!ok)
    begin
      failed_tests++;
    end
    $display("test %s: %s, %0d pairs, %0d with a control transfer, %0d errors",
             name, ok ? "ok" : "failed", pairs - pairs_start, ctrl_pairs - ctrl_start,
             check_errors - errors_start);
  endtask

  initial
  begin
    int t;
    reset         <= 1'b1;
    fe_cmd_v      <= 1'b0;
    fe_cmd_opcode <= e_op_pc_redirect;
    fe_cmd_vaddr  <= '0;
    queue_ready   <= 1'b0;
    rng_state     = 32'h81d6927f;
    timed_out     = 1'b0;
    test_count    = 0;
    failed_tests  = 0;
    repeat (10) @(posedge clk);
    reset <= 1'b0;
    for (t = 0; t < 6 && !timed_out; t++)
    begin
      run_test(t);
    end
    // counts from the last checked edge settle by the falling edge
    @(negedge clk);
    $display("summary: %0d tests, %0d failed, %0d pairs checked, %0d errors",
             test_count, failed_tests, pairs, check_errors);
    if (!timed_out && failed_tests == 0 && check_errors == 0)
    begin
      $display("TESTS PASSED");
    end
    else
    begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

/* verification/fe_checker.sv */
// checker with a reference model of the fetch pair sequence
// compares every accepted pair plus the hold, reset and wait rules
`timescale 1ns/10ps

module fe_checker (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   fe_cmd_v_i,
  input  fe_pkg::fe_cmd_opcode_e fe_cmd_opcode_i,
  input  fe_pkg::vaddr_t         fe_cmd_vaddr_i,
  input  logic                   queue_ready_i,
  input  logic                   queue0_v_i,
  input  fe_pkg::vaddr_t         queue0_pc_i,
  input  fe_pkg::instr_t         queue0_instr_i,
  input  logic                   queue1_v_i,
  input  fe_pkg::vaddr_t         queue1_pc_i,
  input  fe_pkg::instr_t         queue1_instr_i,
  output int                     pairs_o,
  output int                     ctrl_pairs_o,
  output int                     errors_o
);
  import fe_pkg::*;

  // own copy of the memory image
  instr_t image [0:(1 << imem_idx_width_c)-1];

  vaddr_t exp_pc = reset_pc_c;
  logic   reset_q = 1'b0;
  logic   waiting = 1'b0;
  logic   hold_pending = 1'b0;
  logic   held_v1;
  vaddr_t held_pc0;
  vaddr_t held_pc1;
  instr_t held_instr0;
  instr_t held_instr1;
  instr_t exp_w0;
  instr_t exp_w1;
  logic   exp_v1;
  vaddr_t next_pc;
  int     pair_count = 0;
  int     ctrl_count = 0;
  int     error_count = 0;
  int     pairs_r = 0;
  int     ctrl_r = 0;
  int     errors_r = 0;

  initial
  begin
    $readmemh(imem_file_c, image);
  end

  // expected pair at pc
  // a control transfer in slot 0 kills slot 1 and restarts one word later
  function automatic void predict_pair(input vaddr_t pc, output instr_t word0,
                                       output instr_t word1, output logic slot1_v,
                                       output vaddr_t pc_after);
    vaddr_t     pc1;
    logic [6:0] op;
    pc1 = pc + 32'd4;
    word0 = image[pc[imem_idx_width_c+1:2]];
    word1 = image[pc1[imem_idx_width_c+1:2]];
    op = word0[6:0];
    slot1_v = !((op == rv_opcode_branch_c) || (op == rv_opcode_jal_c)
                || (op == rv_opcode_jalr_c));
    pc_after = slot1_v ? (pc + 32'd8) : pc1;
  endfunction

  task automatic expect_word(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp)
    begin
      error_count++;
      $display("FAIL %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  always @(posedge clk_i)
  begin
    // valids stay low through reset and the first edge after it
    if (reset_q && (queue0_v_i !== 1'b0 || queue1_v_i !== 1'b0))
    begin
      error_count++;
      $display("FAIL %0t ns: queue valids are %b %b around reset", $time, queue0_v_i,
               queue1_v_i);
    end
    if (reset_i)
    begin
      exp_pc = reset_pc_c;
      waiting = 1'b0;
      hold_pending = 1'b0;
    end
    else
    begin
      if (waiting && queue0_v_i !== 1'b0)
      begin
        error_count++;
        $display("FAIL %0t ns: pair offered while fetch waits for a redirect", $time);
      end
      // a pair that was refused must come back unchanged
      if (hold_pending)
      begin
        expect_word("held slot 0 valid", 32'(queue0_v_i), 32'd1);
        expect_word("held slot 0 pc", queue0_pc_i, held_pc0);
        expect_word("held slot 0 instr", queue0_instr_i, held_instr0);
        expect_word("held slot 1 valid", 32'(queue1_v_i), 32'(held_v1));
        if (held_v1)
        begin
          expect_word("held slot 1 pc", queue1_pc_i, held_pc1);
          expect_word("held slot 1 instr", queue1_instr_i, held_instr1);
        end
      end
      hold_pending = 1'b0;
      if (queue0_v_i === 1'b1 && queue_ready_i === 1'b1)
      begin
        predict_pair(exp_pc, exp_w0, exp_w1, exp_v1, next_pc);
        expect_word("slot 0 pc", queue0_pc_i, exp_pc);
        expect_word("slot 0 instr", queue0_instr_i, exp_w0);
        expect_word("slot 1 valid", 32'(queue1_v_i), 32'(exp_v1));
        if (exp_v1)
        begin
          expect_word("slot 1 pc", queue1_pc_i, exp_pc + 32'd4);
          expect_word("slot 1 instr", queue1_instr_i, exp_w1);
        end
        else
        begin
          ctrl_count++;
        end
        pair_count++;
        exp_pc = next_pc;
      end
      else if (queue0_v_i === 1'b1 && !fe_cmd_v_i)
      begin
        hold_pending = 1'b1;
        held_pc0 = queue0_pc_i;
        held_instr0 = queue0_instr_i;
        held_v1 = queue1_v_i;
        held_pc1 = queue1_pc_i;
        held_instr1 = queue1_instr_i;
      end
      // commands override whatever the pair would have led to
      if (fe_cmd_v_i && fe_cmd_opcode_i == e_op_pc_redirect)
      begin
        exp_pc = fe_cmd_vaddr_i;
        waiting = 1'b0;
      end
      else if (fe_cmd_v_i && fe_cmd_opcode_i == e_op_wait)
      begin
        waiting = 1'b1;
      end
    end
    reset_q = reset_i;
    pairs_r <= pair_count;
    ctrl_r <= ctrl_count;
    errors_r <= error_count;
  end

  assign pairs_o = pairs_r;
  assign ctrl_pairs_o = ctrl_r;
  assign errors_o = errors_r;

endmodule

/* source/fe_top.sv */
// dual-issue fetch front end top level
// pc generator, two fetch lanes and the pair packer
`timescale 1ns/10ps

module fe_top (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    fe_cmd_v_i,
  input  fe_pkg::fe_cmd_opcode_e  fe_cmd_opcode_i,
  input  fe_pkg::vaddr_t          fe_cmd_vaddr_i,
  input  logic                    queue_ready_i,
  output logic                    queue0_v_o,
  output fe_pkg::vaddr_t          queue0_pc_o,
  output fe_pkg::instr_t          queue0_instr_o,
  output logic                    queue1_v_o,
  output fe_pkg::vaddr_t          queue1_pc_o,
  output fe_pkg::instr_t          queue1_instr_o
);
  import fe_pkg::*;

  // pc generator to lanes
  logic   fetch_v;
  vaddr_t fetch_pc0;
  vaddr_t fetch_pc1;
  logic   flush;

  // packer back to pc generator and lanes
  logic   advance;
  logic   resteer_v;
  vaddr_t resteer_pc;

  // registered slots out of the lanes
  logic   lane0_v;
  vaddr_t lane0_pc;
  instr_t lane0_instr;
  logic   lane1_v;
  vaddr_t lane1_pc;
  instr_t lane1_instr;

  fetch_pc_gen i_fetch_pc_gen (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .fe_cmd_v_i      (fe_cmd_v_i),
    .fe_cmd_opcode_i (fe_cmd_opcode_i),
    .fe_cmd_vaddr_i  (fe_cmd_vaddr_i),
    .advance_i       (advance),
    .resteer_v_i     (resteer_v),
    .resteer_pc_i    (resteer_pc),
    .fetch_v_o       (fetch_v),
    .fetch_pc0_o     (fetch_pc0),
    .fetch_pc1_o     (fetch_pc1),
    .flush_o         (flush)
  );

  // lane 0 fetches the pair pc
  fetch_lane lane0 (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .advance_i (advance),
    .flush_i   (flush),
    .fetch_v_i (fetch_v),
    .pc_i      (fetch_pc0),
    .v_o       (lane0_v),
    .pc_o      (lane0_pc),
    .instr_o   (lane0_instr)
  );

  // lane 1 fetches the word after it
  fetch_lane lane1 (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .advance_i (advance),
    .flush_i   (flush),
    .fetch_v_i (fetch_v),
    .pc_i      (fetch_pc1),
    .v_o       (lane1_v),
    .pc_o      (lane1_pc),
    .instr_o   (lane1_instr)
  );

  issue_pair_pack i_issue_pair_pack (
    .lane0_v_i      (lane0_v),
    .lane0_pc_i     (lane0_pc),
    .lane0_instr_i  (lane0_instr),
    .lane1_v_i      (lane1_v),
    .lane1_pc_i     (lane1_pc),
    .lane1_instr_i  (lane1_instr),
    .queue_ready_i  (queue_ready_i),
    .queue0_v_o     (queue0_v_o),
    .queue0_pc_o    (queue0_pc_o),
    .queue0_instr_o (queue0_instr_o),
    .queue1_v_o     (queue1_v_o),
    .queue1_pc_o    (queue1_pc_o),
    .queue1_instr_o (queue1_instr_o),
    .advance_o      (advance),
    .resteer_v_o    (resteer_v),
    .resteer_pc_o   (resteer_pc)
  );

endmodule

/* source/issue_pair_pack.sv */
// pair packer that scans slot 0 for a control transfer
// drives both queue slots plus the advance and resteer strobes
`timescale 1ns/10ps

module issue_pair_pack (
  input  logic            lane0_v_i,
  input  fe_pkg::vaddr_t  lane0_pc_i,
  input  fe_pkg::instr_t  lane0_instr_i,
  input  logic            lane1_v_i,
  input  fe_pkg::vaddr_t  lane1_pc_i,
  input  fe_pkg::instr_t  lane1_instr_i,
  input  logic            queue_ready_i,
  output logic            queue0_v_o,
  output fe_pkg::vaddr_t  queue0_pc_o,
  output fe_pkg::instr_t  queue0_instr_o,
  output logic            queue1_v_o,
  output fe_pkg::vaddr_t  queue1_pc_o,
  output fe_pkg::instr_t  queue1_instr_o,
  output logic            advance_o,
  output logic            resteer_v_o,
  output fe_pkg::vaddr_t  resteer_pc_o
);
  import fe_pkg::*;

  logic [6:0] major_op;
  logic       is_ctrl;
  logic       accept;

  // major opcode of slot 0
  assign major_op = lane0_instr_i[6:0];

  // branch, jal and jalr all end the pair
  assign is_ctrl = (major_op == rv_opcode_branch_c)
                 | (major_op == rv_opcode_jal_c)
                 | (major_op == rv_opcode_jalr_c);

  // pair leaves on a ready cycle with slot 0 valid
  assign accept = lane0_v_i & queue_ready_i;

  // slot 0 goes out as fetched
  assign queue0_v_o     = lane0_v_i;
  assign queue0_pc_o    = lane0_pc_i;
  assign queue0_instr_o = lane0_instr_i;

  // slot 1 is dropped behind a control transfer
  assign queue1_v_o     = lane1_v_i & ~is_ctrl;
  assign queue1_pc_o    = lane1_pc_i;
  assign queue1_instr_o = lane1_instr_i;

  // lanes may refill when empty or when the queue takes the pair
  assign advance_o = ~lane0_v_i | queue_ready_i;

  // restart right behind the control transfer
  // taken targets come back later as back-end redirects
  assign resteer_v_o  = accept & is_ctrl;
  assign resteer_pc_o = lane0_pc_i + instr_bytes_c;

endmodule

/* source/fetch_lane.sv */
// one fetch lane with an instruction memory read port
// and the registered slot that feeds the pair packer
`timescale 1ns/10ps

module fetch_lane (
  input  logic            clk_i,
  input  logic            reset_i,
  input  logic            advance_i,
  input  logic            flush_i,
  input  logic            fetch_v_i,
  input  fe_pkg::vaddr_t  pc_i,
  output logic            v_o,
  output fe_pkg::vaddr_t  pc_o,
  output fe_pkg::instr_t  instr_o
);
  import fe_pkg::*;

  instr_t                      mem_r [0:(1 << imem_idx_width_c)-1];
  logic [imem_idx_width_c-1:0] idx;
  logic                        v_r;
  vaddr_t                      pc_r;
  instr_t                      instr_r;

  // image is loaded once at start
  initial
  begin
    $readmemh(imem_file_c, mem_r);
  end

  // word index above the byte offset, upper pc bits wrap
  assign idx = pc_i[imem_off_width_c +: imem_idx_width_c];

  // flush drops the slot, advance refills it
  always_ff @(posedge clk_i)
  begin
    if (reset_i || flush_i)
    begin
      v_r <= 1'b0;
    end
    else if (advance_i)
    begin
      v_r <= fetch_v_i;
    end
  end

  // payload only moves with its valid
  always_ff @(posedge clk_i)
  begin
    if (advance_i && !flush_i)
    begin
      pc_r    <= pc_i;
      instr_r <= mem_r[idx];
    end
  end

  assign v_o     = v_r;
  assign pc_o    = pc_r;
  assign instr_o = instr_r;

endmodule

/* source/fetch_pc_gen.sv */
// fetch pc generator with run/idle state and the pair pc register
// decodes back-end commands and raises the lane flush
`timescale 1ns/10ps

module fetch_pc_gen (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    fe_cmd_v_i,
  input  fe_pkg::fe_cmd_opcode_e  fe_cmd_opcode_i,
  input  fe_pkg::vaddr_t          fe_cmd_vaddr_i,
  input  logic                    advance_i,
  input  logic                    resteer_v_i,
  input  fe_pkg::vaddr_t          resteer_pc_i,
  output logic                    fetch_v_o,
  output fe_pkg::vaddr_t          fetch_pc0_o,
  output fe_pkg::vaddr_t          fetch_pc1_o,
  output logic                    flush_o
);
  import fe_pkg::*;

  // idle parks fetch after a wait until the next redirect
  typedef enum logic {
    e_idle = 1'b0,
    e_run  = 1'b1
  } state_e;

  state_e state_r;
  vaddr_t pc_r;

  logic redirect_v;
  logic wait_v;

  // only two opcodes are decoded
  // the reserved codes fall through and change nothing
  assign redirect_v = fe_cmd_v_i & (fe_cmd_opcode_i == e_op_pc_redirect);
  assign wait_v     = fe_cmd_v_i & (fe_cmd_opcode_i == e_op_wait);

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r <= e_run;
    end
    else if (redirect_v)
    begin
      state_r <= e_run;
    end
    else if (wait_v)
    begin
      state_r <= e_idle;
    end
  end

  // commands win over a resteer in the same cycle
  // a wait just holds the pc where it is
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      pc_r <= reset_pc_c;
    end
    else if (redirect_v)
    begin
      pc_r <= fe_cmd_vaddr_i;
    end
    else if (!wait_v)
    begin
      if (resteer_v_i)
      begin
        pc_r <= resteer_pc_i;
      end
      else if (advance_i && (state_r == e_run))
      begin
        pc_r <= pc_r + pair_bytes_c;
      end
    end
  end

  assign fetch_v_o   = (state_r == e_run);
  assign fetch_pc0_o = pc_r;
  // second lane always reads the next word
  assign fetch_pc1_o = pc_r + instr_bytes_c;

  // anything that moves the pc off the straight line kills the pair in flight
  assign flush_o = redirect_v | wait_v | resteer_v_i;

endmodule

/* common/fe_pkg.sv */
// shared widths, word types and back-end command opcodes of the fetch front end
// reset pc, pair stride, instruction memory and control-transfer opcode constants
package fe_pkg;

  // one word per fetch pc and per instruction
  localparam int vaddr_width_c = 32;
  localparam int instr_width_c = 32;

  typedef logic [vaddr_width_c-1:0] vaddr_t;
  typedef logic [instr_width_c-1:0] instr_t;

  // back-end command opcodes
  // codes 2 and 3 are left over from the full command set and ignored
  typedef enum logic [1:0] {
    e_op_pc_redirect = 2'd0,
    e_op_wait        = 2'd1,
    e_op_rsvd2       = 2'd2,
    e_op_rsvd3       = 2'd3
  } fe_cmd_opcode_e;

  // first pair fetched after reset
  localparam vaddr_t reset_pc_c = 32'h0000_0000;

  // slot 1 sits one word above slot 0
  localparam vaddr_t instr_bytes_c = 32'd4;
  // pc step once a full pair has gone out
  localparam vaddr_t pair_bytes_c = 32'd8;

  // 32-word instruction memory
  // index is taken from pc bits above the byte offset, so addresses wrap
  localparam int imem_idx_width_c = 5;
  localparam int imem_off_width_c = 2;

  // memory image, read by the lanes at load time
  localparam string imem_file_c = "instr_mem.hex";

  // RISC-V major opcodes that end a fetch pair
  localparam logic [6:0] rv_opcode_branch_c = 7'b1100011;
  localparam logic [6:0] rv_opcode_jal_c    = 7'b1101111;
  localparam logic [6:0] rv_opcode_jalr_c   = 7'b1100111;

endpackage
